// File: sources.f
design/fetch_pkg.sv
design/tlb_table.sv
design/itlb_stage.sv
design/pre_if_stage.sv
design/fetch_stage.sv
design/fetch_frontend.sv
test/fetch_checker.sv
test/fetch_tb.sv

// File: test/fetch_tb.sv
`timescale 1ns/10ps

module fetch_tb;

    localparam logic [31:0] reset_pc    = 32'hbfc0_0000;
    localparam int          tlb_entries = 8;

    logic                  clk = 1'b0;
    logic                  reset;
    fetch_pkg::br_bus_t    br_bus;
    fetch_pkg::bpu_bus_t   bpu_bus;
    logic                  flush;
    logic [31:0]           exception_addr;
    logic                  eret;
    logic [31:0]           epc;
    logic                  tlb_we;
    fetch_pkg::tlb_entry_t tlb_wentry;
    logic                  imem_req_valid;
    logic [31:0]           imem_req_addr;
    logic                  imem_req_ready;
    logic                  imem_resp_valid;
    logic [31:0]           imem_resp_data;
    logic                  fs_to_ds_valid;
    fetch_pkg::fs_to_ds_t  fs_to_ds;
    logic                  ds_ready;

    fetch_pkg::fs_to_ds_t got_q [$];   // packets taken by decode
    logic [31:0]          req_q [$];   // addresses accepted by memory
    int          pkt_mark;             // queue sizes at the last redirect edge
    int          req_mark;
    int          resp_wait = 0;        // cycles until the pending response
    logic [31:0] resp_addr;
    logic        rand_mode = 1'b0;     // random ready on both ports
    int          seed = 32004;
    int          errors;
    int          err_at_start;
    int          tests_run;
    int          tests_bad;

    fetch_frontend #(
        .reset_pc    (reset_pc),
        .tlb_entries (tlb_entries)
    ) dut (
        .clk             (clk),
        .reset           (reset),
        .br_bus          (br_bus),
        .bpu_bus         (bpu_bus),
        .flush           (flush),
        .exception_addr  (exception_addr),
        .eret            (eret),
        .epc             (epc),
        .tlb_we          (tlb_we),
        .tlb_wentry      (tlb_wentry),
        .imem_req_valid  (imem_req_valid),
        .imem_req_addr   (imem_req_addr),
        .imem_req_ready  (imem_req_ready),
        .imem_resp_valid (imem_resp_valid),
        .imem_resp_data  (imem_resp_data),
        .fs_to_ds_valid  (fs_to_ds_valid),
        .fs_to_ds        (fs_to_ds),
        .ds_ready        (ds_ready)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] kseg_paddr(input logic [31:0] va);
        return va & 32'h1fff_ffff;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] pa);
        return pa ^ 32'h5a5a_5a5a;
    endfunction

    function automatic fetch_pkg::fs_to_ds_t good_pkt(input logic [31:0] va,
                                                      input logic [31:0] pa);
        fetch_pkg::fs_to_ds_t p;
        p.pc       = va;
        p.inst     = mem_word(pa);
        p.ex       = 1'b0;
        p.exc_code = fetch_pkg::no_ex;
        return p;
    endfunction

    function automatic fetch_pkg::br_bus_t branch(input logic predicted, input logic right,
                                                  input logic taken, input logic [31:0] target,
                                                  input logic [31:0] br_pc);
        fetch_pkg::br_bus_t b;
        b.bpu_valid = predicted;
        b.is_branch = 1'b1;
        b.taken     = taken;
        b.bpu_right = right;
        b.target    = target;
        b.pc        = br_pc;
        return b;
    endfunction

    function automatic fetch_pkg::tlb_entry_t make_entry(input logic [18:0] vpn2,
                                                         input logic [19:0] pfn0, input logic v0,
                                                         input logic [19:0] pfn1, input logic v1);
        fetch_pkg::tlb_entry_t e;
        e.vpn2 = vpn2;
        e.pfn0 = pfn0;
        e.v0   = v0;
        e.pfn1 = pfn1;
        e.v1   = v1;
        return e;
    endfunction

    // decode and memory handshakes seen at the rising edge
    always @(posedge clk) begin
        if (reset) begin
            resp_wait = 0;
        end else begin
            if (fs_to_ds_valid && ds_ready)
                got_q.push_back(fs_to_ds);
            if (imem_req_valid && imem_req_ready) begin
                req_q.push_back(imem_req_addr);
                resp_addr = imem_req_addr;
                resp_wait = 1 + $unsigned($random(seed)) % 3;   // 1 to 3 cycles
            end
        end
    end

    always @(negedge clk) begin : mem_drive
        int r;
        imem_resp_valid = 1'b0;
        if (resp_wait > 0) begin
            resp_wait = resp_wait - 1;
            if (resp_wait == 0) begin
                imem_resp_valid = 1'b1;
                imem_resp_data  = mem_word(resp_addr);
            end
        end
        r = $random(seed);
        imem_req_ready = rand_mode ? r[0] : 1'b1;
        if (rand_mode)
            ds_ready = r[1];
    end

    task automatic check_pkt(input fetch_pkg::fs_to_ds_t got, input fetch_pkg::fs_to_ds_t exp,
                             input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s: got pc %h inst %h ex %b code %0d",
                     $time, what, got.pc, got.inst, got.ex, got.exc_code);
            $display("    expected pc %h inst %h ex %b code %0d",
                     exp.pc, exp.inst, exp.ex, exp.exc_code);
            errors++;
        end
    endtask

    task automatic check_addr(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s: got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_exc(input logic got_ex, input fetch_pkg::exc_code_t got,
                             input fetch_pkg::exc_code_t exp, input string what);
        if (got_ex !== (exp != fetch_pkg::no_ex) || got !== exp) begin
            $display("CHECK FAILED at %0t: %s: got ex %b code %0d, expected code %0d",
                     $time, what, got_ex, got, exp);
            errors++;
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset     = 1'b1;
        rand_mode = 1'b0;
        ds_ready  = 1'b1;
        br_bus    = '0;
        bpu_bus   = '0;
        eret      = 1'b0;
        flush     = 1'b0;
        tlb_we    = 1'b0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        got_q.delete();
        req_q.delete();
        pkt_mark     = 0;
        req_mark     = 0;
        err_at_start = errors;
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors == err_at_start) begin
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: %0d errors", name, errors - err_at_start);
        end
    endtask

    task automatic wait_packets(input int want, input int limit, output bit ok);
        int cycles;
        cycles = 0;
        while (got_q.size() < want && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        ok = (got_q.size() >= want);
        if (!ok) begin
            $display("timeout: decode received %0d of %0d packets", got_q.size(), want);
            errors++;
        end
    endtask

    // pulses a redirect for one cycle and marks the queues after its edge
    task automatic pulse_redirect(input fetch_pkg::br_bus_t br, input logic ret,
                                  input logic [31:0] ret_pc, input logic flu,
                                  input logic [31:0] flu_addr);
        @(negedge clk);
        br_bus         = br;
        eret           = ret;
        epc            = ret_pc;
        flush          = flu;
        exception_addr = flu_addr;
        @(negedge clk);
        br_bus   = '0;
        eret     = 1'b0;
        flush    = 1'b0;
        pkt_mark = got_q.size();
        req_mark = req_q.size();
    endtask

    task automatic write_tlb(input fetch_pkg::tlb_entry_t e);
        @(negedge clk);
        tlb_we     = 1'b1;
        tlb_wentry = e;
        @(negedge clk);
        tlb_we = 1'b0;
    endtask

    // n sequential packets after the mark with va and pa stepping together
    task automatic expect_run(input logic [31:0] va0, input logic [31:0] pa0, input int n,
                              input int limit);
        bit ok;
        wait_packets(pkt_mark + n, limit, ok);
        if (ok) begin
            for (int i = 0; i < n; i++) begin
                check_pkt(got_q[pkt_mark + i], good_pkt(va0 + 4 * i, pa0 + 4 * i), "packet");
                check_addr(req_q[req_mark + i], pa0 + 4 * i, "request address");
            end
        end
    endtask

    task automatic expect_faults(input logic [31:0] va0, input fetch_pkg::exc_code_t code,
                                 input int n);
        bit ok;
        wait_packets(pkt_mark + n, 200, ok);
        if (ok) begin
            for (int i = 0; i < n; i++) begin
                check_addr(got_q[pkt_mark + i].pc, va0 + 4 * i, "faulting packet pc");
                check_exc(got_q[pkt_mark + i].ex, got_q[pkt_mark + i].exc_code, code,
                          "faulting packet");
            end
            if (req_q.size() != req_mark) begin
                $display("CHECK FAILED at %0t: faulting fetch sent %0d memory requests",
                         $time, req_q.size() - req_mark);
                errors++;
            end
        end
    endtask

    task automatic sequential_fetch();
        apply_reset();
        expect_run(reset_pc, kseg_paddr(reset_pc), 6, 200);
        report_test("sequential fetch");
    endtask

    task automatic branch_redirect();
        logic [31:0] exp_pc [3];
        bit          ok;
        apply_reset();
        bpu_bus.target = 32'h8000_0400;   // in place before the first transfer
        bpu_bus.valid  = 1'b1;
        exp_pc = '{reset_pc, 32'h8000_0400, 32'h8000_0400};
        wait_packets(3, 200, ok);
        if (ok) begin
            for (int i = 0; i < 3; i++) begin
                check_pkt(got_q[i], good_pkt(exp_pc[i], kseg_paddr(exp_pc[i])), "hinted packet");
                check_addr(req_q[i], kseg_paddr(exp_pc[i]), "hinted request");
            end
        end
        bpu_bus = '0;
        pulse_redirect(branch(1'b1, 1'b0, 1'b1, 32'h8000_1000, 32'h8000_0400),
                       1'b0, '0, 1'b0, '0);
        expect_run(32'h8000_1000, kseg_paddr(32'h8000_1000), 3, 200);
        // wrong guess and not taken resumes past the delay slot
        pulse_redirect(branch(1'b1, 1'b0, 1'b0, 32'h8000_5000, 32'ha000_2000),
                       1'b0, '0, 1'b0, '0);
        expect_run(32'ha000_2008, kseg_paddr(32'ha000_2008), 3, 200);
        report_test("branch redirect");
    endtask

    task automatic eret_over_flush();
        apply_reset();
        pulse_redirect('0, 1'b1, 32'h8000_3000, 1'b1, 32'h8000_0180);
        expect_run(32'h8000_3000, kseg_paddr(32'h8000_3000), 3, 200);
        pulse_redirect('0, 1'b0, '0, 1'b1, 32'h8000_0180);
        expect_run(32'h8000_0180, kseg_paddr(32'h8000_0180), 3, 200);
        report_test("eret over flush");
    endtask

    task automatic fetch_faults();
        apply_reset();
        pulse_redirect(branch(1'b0, 1'b0, 1'b1, 32'h8000_0102, 32'h8000_00f0),
                       1'b0, '0, 1'b0, '0);
        expect_faults(32'h8000_0102, fetch_pkg::adel, 2);
        pulse_redirect(branch(1'b0, 1'b0, 1'b1, 32'h0040_0000, 32'h8000_0100),
                       1'b0, '0, 1'b0, '0);
        expect_faults(32'h0040_0000, fetch_pkg::tlbl, 2);
        write_tlb(make_entry(19'h300, 20'h11111, 1'b0, 20'h22222, 1'b1));   // even page invalid
        pulse_redirect(branch(1'b0, 1'b0, 1'b1, 32'h0060_0000, 32'h8000_0100),
                       1'b0, '0, 1'b0, '0);
        expect_faults(32'h0060_0000, fetch_pkg::tlbl, 1);
        report_test("fetch faults");
    endtask

    task automatic tlb_translation();
        fetch_pkg::tlb_entry_t e;
        apply_reset();
        e = make_entry(19'h100, 20'h00123, 1'b1, 20'h00456, 1'b1);
        write_tlb(e);
        pulse_redirect(branch(1'b0, 1'b0, 1'b1, 32'h0020_0010, 32'h8000_0100),
                       1'b0, '0, 1'b0, '0);
        expect_run(32'h0020_0010, 32'h0012_3010, 2, 200);
        pulse_redirect(branch(1'b0, 1'b0, 1'b1, 32'h0020_1020, 32'h0020_0100),
                       1'b0, '0, 1'b0, '0);
        expect_run(32'h0020_1020, 32'h0045_6020, 2, 200);   // odd page
        e.pfn0 = 20'h00789;
        write_tlb(e);
        pulse_redirect(branch(1'b0, 1'b0, 1'b1, 32'h0020_0030, 32'h0020_1100),
                       1'b0, '0, 1'b0, '0);
        expect_run(32'h0020_0030, 32'h0078_9030, 2, 200);
        report_test("tlb translation");
    endtask

    task automatic random_back_pressure();
        apply_reset();
        rand_mode = 1'b1;
        expect_run(reset_pc, kseg_paddr(reset_pc), 40, 2000);
        rand_mode = 1'b0;
        ds_ready  = 1'b1;
        report_test("random back-pressure");
    endtask

    initial begin
        reset           = 1'b1;
        br_bus          = '0;
        bpu_bus         = '0;
        flush           = 1'b0;
        exception_addr  = '0;
        eret            = 1'b0;
        epc             = '0;
        tlb_we          = 1'b0;
        tlb_wentry      = '0;
        imem_req_ready  = 1'b0;
        imem_resp_valid = 1'b0;
        imem_resp_data  = '0;
        ds_ready        = 1'b1;
        errors          = 0;
        tests_run       = 0;
        tests_bad       = 0;
        pkt_mark        = 0;
        req_mark        = 0;

        sequential_fetch();
        branch_redirect();
        eret_over_flush();
        fetch_faults();
        tlb_translation();
        random_back_pressure();

        errors = errors + dut.u_checker.fail_count;
        $display("%0d tests run, %0d with errors, %0d errors in total",
                 tests_run, tests_bad, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// File: test/fetch_checker.sv
`timescale 1ns/10ps

module fetch_checker (
    input logic                 clk,
    input logic                 reset,
    input logic                 imem_req_valid,
    input logic [31:0]          imem_req_addr,
    input logic                 imem_req_ready,
    input logic                 fs_to_ds_valid,
    input fetch_pkg::fs_to_ds_t fs_to_ds,
    input logic                 ds_ready
);

    int fail_count = 0;

    // a stalled request keeps its address until memory takes it
    req_hold: assert property (
        @(posedge clk) disable iff (reset)
        imem_req_valid && !imem_req_ready |=> imem_req_valid && $stable(imem_req_addr)
    ) else begin
        $error("imem request dropped or changed before ready");
        fail_count++;
    end

    out_hold: assert property (
        @(posedge clk) disable iff (reset)
        fs_to_ds_valid && !ds_ready |=> fs_to_ds_valid && $stable(fs_to_ds)
    ) else begin
        $error("decode packet dropped or changed while decode stalled");
        fail_count++;
    end

    // both ports come up idle
    quiet_after_reset: assert property (
        @(posedge clk) reset |=> !imem_req_valid && !fs_to_ds_valid
    ) else begin
        $error("valid output high in the cycle after reset");
        fail_count++;
    end

endmodule

bind fetch_frontend fetch_checker u_checker (
    .clk            (clk),
    .reset          (reset),
    .imem_req_valid (imem_req_valid),
    .imem_req_addr  (imem_req_addr),
    .imem_req_ready (imem_req_ready),
    .fs_to_ds_valid (fs_to_ds_valid),
    .fs_to_ds       (fs_to_ds),
    .ds_ready       (ds_ready)
);

// File: design/fetch_frontend.sv
`timescale 1ns/10ps

module fetch_frontend #(
    parameter logic [31:0] reset_pc    = 32'hbfc0_0000,
    parameter int          tlb_entries = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  fetch_pkg::br_bus_t    br_bus,
    input  fetch_pkg::bpu_bus_t   bpu_bus,
    input  logic                  flush,
    input  logic [31:0]           exception_addr,
    input  logic                  eret,
    input  logic [31:0]           epc,
    input  logic                  tlb_we,
    input  fetch_pkg::tlb_entry_t tlb_wentry,
    output logic                  imem_req_valid,
    output logic [31:0]           imem_req_addr,
    input  logic                  imem_req_ready,
    input  logic                  imem_resp_valid,
    input  logic [31:0]           imem_resp_data,
    output logic                  fs_to_ds_valid,
    output fetch_pkg::fs_to_ds_t  fs_to_ds,
    input  logic                  ds_ready
);

    logic                  fs_allowin;
    logic                  ps_to_fs_valid;
    fetch_pkg::ps_to_fs_t  ps_to_fs;
    logic                  cancel;
    logic [31:0]           pc;
    logic [31:0]           paddr;
    logic                  tlb_ex;
    logic                  tlb_stall;
    logic                  lookup_req;
    logic [18:0]           lookup_vpn2;
    logic                  tlb_hit;
    fetch_pkg::tlb_entry_t tlb_entry;

    pre_if_stage #(
        .reset_pc (reset_pc)
    ) u_pre_if (
        .clk            (clk),
        .reset          (reset),
        .br_bus         (br_bus),
        .bpu_bus        (bpu_bus),
        .flush          (flush),
        .exception_addr (exception_addr),
        .eret           (eret),
        .epc            (epc),
        .tlb_stall      (tlb_stall),
        .tlb_ex         (tlb_ex),
        .paddr          (paddr),
        .fs_allowin     (fs_allowin),
        .pc             (pc),
        .ps_to_fs_valid (ps_to_fs_valid),
        .ps_to_fs       (ps_to_fs),
        .cancel         (cancel)
    );

    itlb_stage #(
        .tlb_entries (tlb_entries)
    ) u_itlb (
        .clk         (clk),
        .reset       (reset),
        .pc          (pc),
        .tlb_flush   (tlb_we),     // any table write invalidates the buffer
        .paddr       (paddr),
        .tlb_ex      (tlb_ex),
        .tlb_stall   (tlb_stall),
        .lookup_req  (lookup_req),
        .lookup_vpn2 (lookup_vpn2),
        .hit         (tlb_hit),
        .entry       (tlb_entry)
    );

    tlb_table #(
        .tlb_entries (tlb_entries)
    ) u_tlb (
        .clk         (clk),
        .reset       (reset),
        .we          (tlb_we),
        .wentry      (tlb_wentry),
        .lookup_req  (lookup_req),
        .lookup_vpn2 (lookup_vpn2),
        .hit         (tlb_hit),
        .entry       (tlb_entry)
    );

    fetch_stage u_fetch (
        .clk             (clk),
        .reset           (reset),
        .ps_to_fs_valid  (ps_to_fs_valid),
        .ps_to_fs        (ps_to_fs),
        .fs_allowin      (fs_allowin),
        .cancel          (cancel),
        .imem_req_valid  (imem_req_valid),
        .imem_req_addr   (imem_req_addr),
        .imem_req_ready  (imem_req_ready),
        .imem_resp_valid (imem_resp_valid),
        .imem_resp_data  (imem_resp_data),
        .fs_to_ds_valid  (fs_to_ds_valid),
        .fs_to_ds        (fs_to_ds),
        .ds_ready        (ds_ready)
    );

endmodule

// File: design/fetch_stage.sv
`timescale 1ns/10ps

module fetch_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 ps_to_fs_valid,
    input  fetch_pkg::ps_to_fs_t ps_to_fs,
    output logic                 fs_allowin,
    input  logic                 cancel,
    output logic                 imem_req_valid,
    output logic [31:0]          imem_req_addr,
    input  logic                 imem_req_ready,
    input  logic                 imem_resp_valid,
    input  logic [31:0]          imem_resp_data,
    output logic                 fs_to_ds_valid,
    output fetch_pkg::fs_to_ds_t fs_to_ds,
    input  logic                 ds_ready
);

    typedef enum logic [2:0] {
        s_idle,
        s_request,
        s_wait,
        s_done,
        s_drop
    } state_t;

    state_t               state;
    state_t               state_nxt;
    logic                 kill;     // request still on the bus but its data is dead
    logic                 accept;
    fetch_pkg::ps_to_fs_t pkt;
    logic [31:0]          inst;

    assign fs_allowin = (state == s_idle) || (state == s_done && ds_ready);
    assign accept     = ps_to_fs_valid && fs_allowin && !cancel;

    assign imem_req_valid = (state == s_request);
    assign imem_req_addr  = pkt.paddr;
    assign fs_to_ds_valid = (state == s_done);

    always_comb begin
        fs_to_ds.pc       = pkt.pc;
        fs_to_ds.inst     = inst;
        fs_to_ds.ex       = pkt.ex;
        fs_to_ds.exc_code = pkt.exc_code;
    end

    always_comb begin
        state_nxt = state;
        case (state)
            s_idle: begin
                if (accept)
                    state_nxt = ps_to_fs.ex ? s_done : s_request;   // faults skip memory
            end
            s_request: begin
                if (imem_req_ready)
                    state_nxt = (kill || cancel) ? s_drop : s_wait;
            end
            s_wait: begin
                if (cancel)
                    state_nxt = imem_resp_valid ? s_idle : s_drop;
                else if (imem_resp_valid)
                    state_nxt = s_done;
            end
            s_done: begin
                if (accept)
                    state_nxt = ps_to_fs.ex ? s_done : s_request;
                else if (ds_ready || cancel)
                    state_nxt = s_idle;
            end
            s_drop: begin
                if (imem_resp_valid)
                    state_nxt = s_idle;   // swallow stale response
            end
            default: state_nxt = s_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= s_idle;
            kill  <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == s_request)
                kill <= imem_req_ready ? 1'b0 : (kill || cancel);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pkt  <= ps_to_fs;
            inst <= '0;
        end else if (state == s_wait && imem_resp_valid) begin
            inst <= imem_resp_data;
        end
    end

endmodule

// File: design/pre_if_stage.sv
`timescale 1ns/10ps

module pre_if_stage #(
    parameter logic [31:0] reset_pc = 32'hbfc0_0000
) (
    input  logic                 clk,
    input  logic                 reset,
    input  fetch_pkg::br_bus_t   br_bus,
    input  fetch_pkg::bpu_bus_t  bpu_bus,
    input  logic                 flush,
    input  logic [31:0]          exception_addr,
    input  logic                 eret,
    input  logic [31:0]          epc,
    input  logic                 tlb_stall,
    input  logic                 tlb_ex,
    input  logic [31:0]          paddr,
    input  logic                 fs_allowin,
    output logic [31:0]          pc,
    output logic                 ps_to_fs_valid,
    output fetch_pkg::ps_to_fs_t ps_to_fs,
    output logic                 cancel
);

    logic        mispredict;
    logic        unpred_taken;
    logic        redirect;
    logic        transfer;
    logic        addr_err;
    logic [31:0] br_fix_pc;
    logic [31:0] redirect_pc;
    logic [31:0] seq_next_pc;

    // predicted wrong, or taken without any prediction
    assign mispredict   = br_bus.is_branch && br_bus.bpu_valid && !br_bus.bpu_right;
    assign unpred_taken = br_bus.is_branch && !br_bus.bpu_valid && br_bus.taken;

    assign redirect = eret || flush || mispredict || unpred_taken;
    assign cancel   = redirect;

    // not taken after a wrong guess resumes past the delay slot
    assign br_fix_pc = (mispredict && !br_bus.taken) ? br_bus.pc + 32'd8 : br_bus.target;

    always_comb begin
        if (eret)
            redirect_pc = epc;
        else if (flush)
            redirect_pc = exception_addr;
        else
            redirect_pc = br_fix_pc;
    end

    assign seq_next_pc = bpu_bus.valid ? bpu_bus.target : pc + 32'd4;

    assign ps_to_fs_valid = !tlb_stall;
    assign transfer       = ps_to_fs_valid && fs_allowin;

    always_ff @(posedge clk) begin
        if (reset)
            pc <= reset_pc;
        else if (redirect)
            pc <= redirect_pc;
        else if (transfer)
            pc <= seq_next_pc;   // held while fetch is full
    end

    assign addr_err = (pc[1:0] != 2'b00);

    always_comb begin
        ps_to_fs.pc    = pc;
        ps_to_fs.paddr = paddr;
        ps_to_fs.ex    = addr_err || tlb_ex;
        if (addr_err)
            ps_to_fs.exc_code = fetch_pkg::adel;   // beats tlbl
        else if (tlb_ex)
            ps_to_fs.exc_code = fetch_pkg::tlbl;
        else
            ps_to_fs.exc_code = fetch_pkg::no_ex;
    end

endmodule

// File: design/itlb_stage.sv
`timescale 1ns/10ps

module itlb_stage #(
    parameter int tlb_entries = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [31:0]           pc,
    input  logic                  tlb_flush,
    output logic [31:0]           paddr,
    output logic                  tlb_ex,
    output logic                  tlb_stall,
    output logic                  lookup_req,
    output logic [18:0]           lookup_vpn2,
    input  logic                  hit,
    input  fetch_pkg::tlb_entry_t entry
);

    typedef enum logic {
        s_idle,
        s_fill
    } state_t;

    state_t      state;
    logic        unmapped;
    logic        buf_valid;     // buffer holds a lookup result
    logic        buf_found;     // that lookup hit the table
    logic [18:0] buf_vpn2;
    logic [19:0] buf_pfn0;
    logic        buf_v0;
    logic [19:0] buf_pfn1;
    logic        buf_v1;
    logic [18:0] req_vpn2;      // vpn2 of the lookup in flight
    logic        buf_hit;
    logic [19:0] page_pfn;
    logic        page_v;

    assign unmapped = (pc >= fetch_pkg::kseg_unmapped_lo) && (pc <= fetch_pkg::kseg_unmapped_hi);
    assign buf_hit  = buf_valid && (buf_vpn2 == pc[31:13]);

    // one lookup cycle and one fill cycle per buffer miss
    assign lookup_vpn2 = pc[31:13];
    assign lookup_req  = (state == s_idle) && !unmapped && !buf_hit;
    assign tlb_stall   = lookup_req || (state == s_fill);

    assign page_pfn = pc[12] ? buf_pfn1 : buf_pfn0;   // odd page on bit 12
    assign page_v   = pc[12] ? buf_v1 : buf_v0;

    assign paddr  = unmapped ? {3'b000, pc[28:0]} : {page_pfn, pc[11:0]};
    assign tlb_ex = !unmapped && buf_hit && !(buf_found && page_v);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= s_idle;
            buf_valid <= 1'b0;
        end else if (tlb_flush) begin
            state     <= s_idle;   // a table write also drops any refill
            buf_valid <= 1'b0;
        end else if (state == s_fill) begin
            state     <= s_idle;
            buf_valid <= 1'b1;
        end else if (lookup_req) begin
            state <= s_fill;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_req)
            req_vpn2 <= lookup_vpn2;
        if (state == s_fill) begin
            buf_vpn2  <= req_vpn2;
            buf_found <= hit;
            buf_pfn0  <= entry.pfn0;
            buf_v0    <= entry.v0;
            buf_pfn1  <= entry.pfn1;
            buf_v1    <= entry.v1;
        end
    end

endmodule

// File: design/tlb_table.sv
`timescale 1ns/10ps

module tlb_table #(
    parameter int tlb_entries = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  we,
    input  fetch_pkg::tlb_entry_t wentry,
    input  logic                  lookup_req,
    input  logic [18:0]           lookup_vpn2,
    output logic                  hit,
    output fetch_pkg::tlb_entry_t entry
);

    localparam int idx_w = (tlb_entries > 1) ? $clog2(tlb_entries) : 1;

    fetch_pkg::tlb_entry_t  entries [tlb_entries];
    logic [tlb_entries-1:0] valid;
    logic [idx_w-1:0]       rr_ptr;     // next victim slot
    logic                   wr_match;
    logic [idx_w-1:0]       wr_idx;
    logic                   lk_match;
    logic [idx_w-1:0]       lk_idx;

    // a write to a vpn2 already present overwrites that slot
    always_comb begin
        wr_match = 1'b0;
        wr_idx   = rr_ptr;
        lk_match = 1'b0;
        lk_idx   = '0;
        for (int i = 0; i < tlb_entries; i++) begin
            if (!wr_match && valid[i] && entries[i].vpn2 == wentry.vpn2) begin
                wr_match = 1'b1;
                wr_idx   = idx_w'(i);
            end
            if (!lk_match && valid[i] && entries[i].vpn2 == lookup_vpn2) begin
                lk_match = 1'b1;
                lk_idx   = idx_w'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid  <= '0;
            rr_ptr <= '0;
        end else if (we) begin
            valid[wr_idx] <= 1'b1;
            if (!wr_match)   // only fresh fills move the pointer
                rr_ptr <= (rr_ptr == idx_w'(tlb_entries - 1)) ? '0 : rr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (we)
            entries[wr_idx] <= wentry;
    end

    // lookup result shows up one cycle after the request
    always_ff @(posedge clk) begin
        if (reset)
            hit <= 1'b0;
        else if (lookup_req)
            hit <= lk_match;
    end

    always_ff @(posedge clk) begin
        if (lookup_req)
            entry <= entries[lk_idx];
    end

endmodule

// File: design/fetch_pkg.sv
package fetch_pkg;

    // exception codes as in the cp0 cause register
    typedef enum logic [4:0] {
        no_ex = 5'd0,
        tlbl  = 5'd2,   // tlb miss or invalid page on fetch
        adel  = 5'd4    // misaligned fetch address
    } exc_code_t;

    // branch resolution from execute
    typedef struct packed {
        logic        bpu_valid;   // predictor had a guess for this branch
        logic        is_branch;
        logic        taken;
        logic        bpu_right;
        logic [31:0] target;
        logic [31:0] pc;
    } br_bus_t;

    // predictor hint for the current fetch pc
    typedef struct packed {
        logic [31:0] target;
        logic        valid;
    } bpu_bus_t;

    typedef struct packed {
        logic [31:0] pc;      // virtual
        logic [31:0] paddr;
        logic        ex;
        exc_code_t   exc_code;
    } ps_to_fs_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic        ex;
        exc_code_t   exc_code;
    } fs_to_ds_t;

    // one even/odd page pair
    typedef struct packed {
        logic [18:0] vpn2;
        logic [19:0] pfn0;
        logic        v0;
        logic [19:0] pfn1;
        logic        v1;
    } tlb_entry_t;

    // kseg0 and kseg1 bypass the tlb
    localparam logic [31:0] kseg_unmapped_lo = 32'h8000_0000;
    localparam logic [31:0] kseg_unmapped_hi = 32'hbfff_ffff;

endpackage
